//--- flist.f
src/console_pkg.sv
src/frame_buffer.sv
src/sample_capture.sv
src/packet_tx.sv
src/command_rx.sv
src/console.sv
src/daq_top.sv
sim/daq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= daq_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/daq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module daq_tb
    import console_pkg::*;
();

    localparam btype_t UNKNOWN_CMD    = 4'd3;
    localparam int     PKT_TIMEOUT    = 20000;
    localparam int     CREDIT_TIMEOUT = 200;
    localparam int     IDLE_WINDOW    = 40;
    localparam int     DATA_CMDS      = 7;

    logic   clk;
    logic   rst;
    logic   adc_valid;
    word_t  adc_data;
    logic   tx_valid;
    word_t  tx_data;
    logic   tx_credit;
    logic   rx_valid;
    btype_t rx_btype;
    logic   rx_credit;

    integer seed = 29;
    int     cycle_cnt = 0;
    int     credit_due_q[$];
    word_t  cap_start_q[$];     // First sample value of each capture
    addr_t  exp_base_q[$];      // Buffer region of each expected capture
    word_t  exp_hdr_q[$];
    logic   cap_req_d = 1'b0;

    int     word_idx = 0;
    len_t   cur_len;
    word_t  cur_start;
    logic   cur_known;
    int     credit_mirror = int'(TX_CREDITS);
    logic   credit_d = 1'b0;
    int     packets_done = 0;
    int     cmds_sent = 0;
    int     credits_back = 0;

    int     mismatch_count = 0;
    int     protocol_count = 0;
    int     sequence_count = 0;
    int     timeout_count = 0;

    daq_top daq_top_i (
        .clk       (clk),
        .rst       (rst),
        .adc_valid (adc_valid),
        .adc_data  (adc_data),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .rx_valid  (rx_valid),
        .rx_btype  (rx_btype),
        .rx_credit (rx_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Front end and host receive credits share one random stream
    initial begin : front_end_and_credits
        word_t       next_sample;
        logic [31:0] rnd;
        addr_t       exp_base;
        adc_valid = 1'b0;
        adc_data  = '0;
        tx_credit = 1'b0;
        forever begin
            @(posedge clk);
            cycle_cnt   = cycle_cnt + 1;
            next_sample = adc_valid ? adc_data + 16'd1 : adc_data;
            adc_data   <= next_sample;
            rnd         = $random(seed);
            adc_valid  <= rnd[0];
            if (daq_top_i.cap_req && !cap_req_d) begin
                cap_start_q.push_back(next_sample);   // Next valid sample opens the record
                if (exp_base_q.size() == 0) begin
                    $display("Capture started at %0t with no command pending", $time);
                    protocol_count++;
                end else begin
                    exp_base = exp_base_q.pop_front();
                    assert (daq_top_i.ram_addr_init == exp_base) else begin
                        $display("mismatch at %0t: ram_addr_init expected %h got %h",
                                 $time, exp_base, daq_top_i.ram_addr_init);
                        mismatch_count++;
                    end
                end
            end
            cap_req_d <= daq_top_i.cap_req;
            if (tx_valid) begin
                rnd = $random(seed);
                credit_due_q.push_back(cycle_cnt + int'(rnd % 32'd6));
            end
            if ((credit_due_q.size() > 0) && (credit_due_q[0] <= cycle_cnt)) begin
                tx_credit <= 1'b1;
                void'(credit_due_q.pop_front());
            end else begin
                tx_credit <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : packet_check
        word_t expected;
        if (tx_valid) begin
            // Mirror lags the DUT credit count by the output register
            assert (credit_mirror > 0) else begin
                $display("Word sent at %0t with no host credit left", $time);
                protocol_count++;
            end
            if (word_idx == 0) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("Unexpected packet with header %h at %0t", tx_data, $time);
                    protocol_count++;
                    cur_known = 1'b0;
                    cur_len   = tx_data[11:0];
                end else begin
                    expected = exp_hdr_q.pop_front();
                    assert (tx_data == expected) else begin
                        $display("mismatch at %0t: tx_data header expected %h got %h",
                                 $time, expected, tx_data);
                        mismatch_count++;
                    end
                    cur_len   = expected[11:0];
                    cur_known = (cap_start_q.size() > 0);
                    if (cur_known) begin
                        cur_start = cap_start_q.pop_front();
                    end else begin
                        $display("Packet at %0t was sent without a capture", $time);
                        protocol_count++;
                    end
                end
                word_idx = 1;
            end else begin
                expected = cur_start + word_t'(word_idx - 1);
                assert (!cur_known || (tx_data == expected)) else begin
                    $display("mismatch at %0t: tx_data word %0d expected %h got %h",
                             $time, word_idx - 1, expected, tx_data);
                    mismatch_count++;
                end
                if (word_idx >= int'(cur_len)) begin
                    word_idx = 0;
                    packets_done <= packets_done + 1;
                end else begin
                    word_idx = word_idx + 1;
                end
            end
        end
        credit_mirror = credit_mirror - (tx_valid ? 1 : 0) + (credit_d ? 1 : 0);
        credit_d      = tx_credit;
        if (rx_credit) begin
            assert (credits_back < cmds_sent) else begin
                $display("Extra rx_credit pulse at %0t with no command outstanding", $time);
                protocol_count++;
            end
            credits_back <= credits_back + 1;
        end
    end

    task automatic wait_command_credit(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < CREDIT_TIMEOUT; n++) begin
            @(posedge clk);
            if (credits_back >= cmds_sent) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout: command credit not returned within %0d cycles", CREDIT_TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic wait_packets(input int target, output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < PKT_TIMEOUT; n++) begin
            @(posedge clk);
            if (packets_done >= target) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout: packet %0d not complete within %0d cycles", target, PKT_TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic issue_command(input btype_t cmd);
        rx_valid  <= 1'b1;
        rx_btype  <= cmd;
        cmds_sent <= cmds_sent + 1;
        @(posedge clk);
        rx_valid  <= 1'b0;
    endtask

    task automatic serve_command(input btype_t cmd, input btype_t pkt, input len_t len,
                                 input addr_t base, output logic ok);
        int target;
        target = packets_done + 1;
        wait_command_credit(ok);
        if (ok) begin
            exp_hdr_q.push_back({pkt, len});
            exp_base_q.push_back(base);
            issue_command(cmd);
            wait_packets(target, ok);
        end
    endtask

    task automatic run_sequence(output logic ok);
        int    blk;
        int    idle_start;
        addr_t region;
        exp_hdr_q.push_back({BAG_DLINK, REC_LEN});
        exp_base_q.push_back(RAM_ADDR_DLINK);
        repeat (4) begin
            @(posedge clk);
            assert (!tx_valid && !rx_credit) else begin
                $display("Host outputs active during reset at %0t", $time);
                sequence_count++;
            end
        end
        rst <= 1'b0;
        wait_packets(1, ok);
        if (!ok) return;
        serve_command(BAG_DIDX, BAG_DTYPE, REC_LEN, RAM_ADDR_DTYPE, ok);
        if (!ok) return;
        serve_command(BAG_DPARAM, BAG_DTEMP, REC_LEN, RAM_ADDR_DTEMP, ok);
        if (!ok) return;
        wait_command_credit(ok);
        if (!ok) return;
        issue_command(UNKNOWN_CMD);
        wait_command_credit(ok);
        if (!ok) return;
        idle_start = packets_done;
        repeat (IDLE_WINDOW) @(posedge clk);
        assert ((packets_done == idle_start) && (cap_start_q.size() == 0)) else begin
            $display("Unknown command started a capture or a packet");
            sequence_count++;
        end
        serve_command(BAG_DIDX, BAG_DTYPE, REC_LEN, RAM_ADDR_DTYPE, ok);
        if (!ok) return;
        for (blk = 0; blk < DATA_CMDS; blk++) begin
            region = RAM_ADDR_DATA0 + addr_t'(blk % int'(NUM_BLOCKS)) * BLOCK_STRIDE;
            serve_command(BAG_DDIDX, (blk % 2 == 0) ? BAG_DATA0 : BAG_DATA1, BLOCK_LEN,
                          region, ok);
            if (!ok) return;
        end
        assert (exp_hdr_q.size() == 0) else begin
            $display("Expected packets were never sent");
            sequence_count++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_count + protocol_count + sequence_count + timeout_count;
        $display("Error counts: mismatch %0d, protocol %0d, sequence %0d, timeout %0d",
                 mismatch_count, protocol_count, sequence_count, timeout_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin : host_sequence
        logic ok;
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_btype = BAG_INIT;
        run_sequence(ok);
        finish_run();
    end

endmodule

`default_nettype wire

//--- src/daq_top.sv
`timescale 1ns/10ps
`default_nettype none

module daq_top
    import console_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire         adc_valid,
    input  wire word_t  adc_data,

    output logic        tx_valid,
    output word_t       tx_data,
    input  wire         tx_credit,

    input  wire         rx_valid,
    input  wire btype_t rx_btype,
    output logic        rx_credit
);

    logic   cap_req;
    logic   cap_done;
    logic   send_req;
    logic   send_done;
    btype_t send_btype;
    logic   cmd_valid;
    btype_t cmd_btype;
    logic   cmd_take;
    addr_t  ram_addr_init;
    len_t   ram_dlen;
    logic   wr_en;
    addr_t  wr_addr;
    word_t  wr_data;
    addr_t  rd_addr;
    word_t  rd_data;

    console console_i (
        .clk           (clk),
        .rst           (rst),
        .cap_req       (cap_req),
        .cap_done      (cap_done),
        .send_req      (send_req),
        .send_done     (send_done),
        .send_btype    (send_btype),
        .cmd_valid     (cmd_valid),
        .cmd_btype     (cmd_btype),
        .cmd_take      (cmd_take),
        .ram_addr_init (ram_addr_init),
        .ram_dlen      (ram_dlen)
    );

    sample_capture sample_capture_i (
        .clk           (clk),
        .rst           (rst),
        .cap_req       (cap_req),
        .ram_addr_init (ram_addr_init),
        .ram_dlen      (ram_dlen),
        .cap_done      (cap_done),
        .adc_valid     (adc_valid),
        .adc_data      (adc_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    frame_buffer frame_buffer_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    packet_tx packet_tx_i (
        .clk           (clk),
        .rst           (rst),
        .send_req      (send_req),
        .send_btype    (send_btype),
        .ram_addr_init (ram_addr_init),
        .ram_dlen      (ram_dlen),
        .send_done     (send_done),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .tx_credit     (tx_credit)
    );

    command_rx command_rx_i (
        .clk       (clk),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_btype  (rx_btype),
        .rx_credit (rx_credit),
        .cmd_valid (cmd_valid),
        .cmd_btype (cmd_btype),
        .cmd_take  (cmd_take)
    );

endmodule

`default_nettype wire

//--- src/console.sv
`timescale 1ns/10ps
`default_nettype none

module console
    import console_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    output logic        cap_req,
    input  wire         cap_done,

    output logic        send_req,
    input  wire         send_done,
    output btype_t      send_btype,

    input  wire         cmd_valid,
    input  wire btype_t cmd_btype,
    output logic        cmd_take,

    output addr_t       ram_addr_init,
    output len_t        ram_dlen
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LINK,
        ST_CAP,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [2:0] block_idx;
    logic       cmd_known;
    addr_t      block_base;

    assign cap_req  = (state == ST_CAP);
    assign send_req = (state == ST_SEND);
    assign cmd_take = (state == ST_WAIT) && cmd_valid;

    assign cmd_known = (cmd_btype == BAG_DIDX) ||
                       (cmd_btype == BAG_DPARAM) ||
                       (cmd_btype == BAG_DDIDX);

    assign block_base = RAM_ADDR_DATA0 + addr_t'(block_idx) * BLOCK_STRIDE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: next_state = ST_LINK;
            ST_LINK: next_state = ST_CAP;   // Link record parameters load here
            ST_CAP: begin
                if (cap_done) begin
                    next_state = ST_SEND;
                end
            end
            ST_SEND: begin
                if (send_done) begin
                    next_state = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (cmd_take && cmd_known) begin
                    next_state = ST_CAP;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Unknown commands are taken and load nothing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_btype    <= BAG_INIT;
            ram_addr_init <= '0;
            ram_dlen      <= '0;
            block_idx     <= '0;
        end else if (state == ST_LINK) begin
            send_btype    <= BAG_DLINK;
            ram_addr_init <= RAM_ADDR_DLINK;
            ram_dlen      <= REC_LEN;
        end else if (cmd_take) begin
            case (cmd_btype)
                BAG_DIDX: begin
                    send_btype    <= BAG_DTYPE;
                    ram_addr_init <= RAM_ADDR_DTYPE;
                    ram_dlen      <= REC_LEN;
                end
                BAG_DPARAM: begin
                    send_btype    <= BAG_DTEMP;
                    ram_addr_init <= RAM_ADDR_DTEMP;
                    ram_dlen      <= REC_LEN;
                end
                BAG_DDIDX: begin
                    send_btype    <= block_idx[0] ? BAG_DATA1 : BAG_DATA0;
                    ram_addr_init <= block_base;
                    ram_dlen      <= BLOCK_LEN;
                    if (block_idx == NUM_BLOCKS - 3'd1) begin
                        block_idx <= '0;            // Wrap back to region 0
                    end else begin
                        block_idx <= block_idx + 3'd1;
                    end
                end
                default: ;
            endcase
        end else if (send_done) begin
            send_btype <= BAG_INIT;
        end
    end

endmodule

`default_nettype wire

//--- src/command_rx.sv
`timescale 1ns/10ps
`default_nettype none

module command_rx
    import console_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire         rx_valid,
    input  wire btype_t rx_btype,
    output logic        rx_credit,

    output logic        cmd_valid,
    output btype_t      cmd_btype,
    input  wire         cmd_take
);

    logic slot_free;

    assign slot_free = !cmd_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            rx_credit <= 1'b0;
        end else begin
            rx_credit <= cmd_take;   // Credit goes back once the slot is free
            if (rx_valid && slot_free) begin
                cmd_valid <= 1'b1;
            end else if (cmd_take) begin
                cmd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && slot_free) begin
            cmd_btype <= rx_btype;
        end
    end

endmodule

`default_nettype wire

//--- src/packet_tx.sv
`timescale 1ns/10ps
`default_nettype none

module packet_tx
    import console_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire         send_req,
    input  wire btype_t send_btype,
    input  wire addr_t  ram_addr_init,
    input  wire len_t   ram_dlen,
    output logic        send_done,

    output addr_t       rd_addr,
    input  wire word_t  rd_data,

    output logic        tx_valid,
    output word_t       tx_data,
    input  wire         tx_credit
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEAD,
        TX_DATA,
        TX_END
    } tx_state_t;

    tx_state_t  state;
    logic [2:0] credits;
    len_t       remain;
    addr_t      rd_ptr;     // Address whose word sits on rd_data
    logic       fire;

    assign fire = ((state == TX_HEAD) || (state == TX_DATA)) && (credits != 3'd0);

    // Next address goes out a cycle early so the RAM keeps up with one word per cycle
    always_comb begin
        if (state == TX_IDLE) begin
            rd_addr = ram_addr_init;
        end else if ((state == TX_DATA) && fire) begin
            rd_addr = rd_ptr + 1'b1;
        end else begin
            rd_addr = rd_ptr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= TX_IDLE;
            credits   <= TX_CREDITS;
            remain    <= '0;
            rd_ptr    <= '0;
            tx_valid  <= 1'b0;
            send_done <= 1'b0;
        end else begin
            rd_ptr    <= rd_addr;
            tx_valid  <= fire;
            send_done <= 1'b0;

            case ({fire, tx_credit})
                2'b10:   credits <= credits - 3'd1;
                2'b01:   credits <= credits + 3'd1;
                default: ;
            endcase

            case (state)
                TX_IDLE: begin
                    if (send_req && !send_done) begin
                        remain <= ram_dlen;
                        state  <= TX_HEAD;
                    end
                end
                TX_HEAD: begin
                    if (fire) begin
                        state <= (remain == '0) ? TX_END : TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (fire) begin
                        remain <= remain - 1'b1;
                        if (remain == len_t'(1)) begin
                            state <= TX_END;
                        end
                    end
                end
                TX_END: begin
                    send_done <= 1'b1;
                    state     <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            tx_data <= (state == TX_HEAD) ? {send_btype, ram_dlen} : rd_data;
        end
    end

endmodule

`default_nettype wire

//--- src/sample_capture.sv
`timescale 1ns/10ps
`default_nettype none

module sample_capture
    import console_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    input  wire        cap_req,
    input  wire addr_t ram_addr_init,
    input  wire len_t  ram_dlen,
    output logic       cap_done,

    input  wire        adc_valid,
    input  wire word_t adc_data,

    output logic       wr_en,
    output addr_t      wr_addr,
    output word_t      wr_data
);

    logic  busy;
    addr_t wr_ptr;
    len_t  remain;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            cap_done <= 1'b0;
            wr_ptr   <= '0;
            remain   <= '0;
        end else begin
            cap_done <= 1'b0;
            if (!busy) begin
                // Request is still high while done is out, so ignore it then
                if (cap_req && !cap_done) begin
                    wr_ptr   <= ram_addr_init;
                    remain   <= ram_dlen;
                    busy     <= (ram_dlen != '0);
                    cap_done <= (ram_dlen == '0);
                end
            end else if (adc_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                remain <= remain - 1'b1;
                if (remain == len_t'(1)) begin
                    busy     <= 1'b0;
                    cap_done <= 1'b1;   // Last word written this cycle
                end
            end
        end
    end

    assign wr_en   = busy && adc_valid;
    assign wr_addr = wr_ptr;
    assign wr_data = adc_data;

endmodule

`default_nettype wire

//--- src/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer
    import console_pkg::*;
(
    input  wire        clk,

    input  wire        wr_en,
    input  wire addr_t wr_addr,
    input  wire word_t wr_data,

    input  wire addr_t rd_addr,
    output word_t      rd_data
);

    word_t mem [0:RAM_DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];   // One cycle read latency
    end

endmodule

`default_nettype wire

//--- src/console_pkg.sv
`default_nettype none

package console_pkg;

    typedef logic [3:0]  btype_t;
    typedef logic [11:0] addr_t;
    typedef logic [11:0] len_t;
    typedef logic [15:0] word_t;

    // Command and packet types
    localparam btype_t BAG_INIT   = 4'h0;
    localparam btype_t BAG_DIDX   = 4'h5;
    localparam btype_t BAG_DPARAM = 4'h6;
    localparam btype_t BAG_DDIDX  = 4'h7;
    localparam btype_t BAG_DLINK  = 4'h8;
    localparam btype_t BAG_DTYPE  = 4'h9;
    localparam btype_t BAG_DTEMP  = 4'hA;
    localparam btype_t BAG_DATA0  = 4'hD;
    localparam btype_t BAG_DATA1  = 4'hE;

    // Frame buffer map
    localparam addr_t RAM_ADDR_DLINK = 12'hFCC;
    localparam addr_t RAM_ADDR_DTYPE = 12'hFC0;
    localparam addr_t RAM_ADDR_DTEMP = 12'hFC4;
    localparam addr_t RAM_ADDR_DATA0 = 12'h000;
    localparam addr_t BLOCK_STRIDE   = 12'h240;  // Block n at DATA0 + n * stride

    localparam int unsigned RAM_DEPTH = 4096;

    localparam logic [2:0] NUM_BLOCKS = 3'd6;

    localparam len_t REC_LEN   = 12'd2;           // Link, type and temperature records
    localparam len_t BLOCK_LEN = 12'h202;         // 514 words per data block

    localparam logic [2:0] TX_CREDITS = 3'd4;     // Host receive slots at reset

endpackage

`default_nettype wire
